//--- verilog/store_pkg.sv
`default_nettype none

package store_pkg;

	parameter int XLEN          = 32;
	parameter int VLEN          = 32;
	parameter int PLEN          = 34;
	parameter int PAGE_BITS     = 12;
	parameter int TRANS_ID_BITS = 3;

	typedef enum logic [3:0] {
		OP_SW, OP_SH, OP_SB,
		OP_AMO_SWAP, OP_AMO_ADD, OP_AMO_AND, OP_AMO_OR, OP_AMO_XOR,
		OP_AMO_MAX, OP_AMO_MIN, OP_AMO_MAXU, OP_AMO_MINU
	} op_t;

	function automatic logic is_amo(input op_t op);
		return op >= OP_AMO_SWAP; // amo codes follow the plain stores.
	endfunction

	// new memory word written back by an amo.
	function automatic logic [XLEN-1:0] amo_result(input op_t op,
			input logic [XLEN-1:0] old_val, input logic [XLEN-1:0] opnd);
		case (op)
			OP_AMO_ADD:  return old_val + opnd;
			OP_AMO_AND:  return old_val & opnd;
			OP_AMO_OR:   return old_val | opnd;
			OP_AMO_XOR:  return old_val ^ opnd;
			OP_AMO_MAX:  return ($signed(old_val) > $signed(opnd)) ? old_val : opnd;
			OP_AMO_MIN:  return ($signed(old_val) < $signed(opnd)) ? old_val : opnd;
			OP_AMO_MAXU: return (old_val > opnd) ? old_val : opnd;
			OP_AMO_MINU: return (old_val < opnd) ? old_val : opnd;
			default:     return opnd; // swap.
		endcase
	endfunction

endpackage

`default_nettype wire

//--- verilog/store_xlate_regs.sv
`timescale 1ns/1ps
`default_nettype none

module store_xlate_regs (
	input  wire                                clk_i,
	input  wire                                rst_ni,
	input  wire                                cfg_cyc_i,
	input  wire                                cfg_stb_i,
	input  wire                                cfg_we_i,
	input  wire                                cfg_adr_i,
	input  wire [store_pkg::XLEN-1:0]          cfg_dat_i,
	output logic [store_pkg::XLEN-1:0]         cfg_dat_o,
	output logic                               cfg_ack_o,
	input  wire [store_pkg::VLEN-1:0]          vaddr_i,
	output logic [store_pkg::PLEN-1:0]         paddr_o,
	output logic                               fault_o
);

	localparam int PPN_BITS = store_pkg::PLEN - store_pkg::PAGE_BITS;
	localparam int VPN_BITS = store_pkg::VLEN - store_pkg::PAGE_BITS;

	logic [PPN_BITS-1:0] base_q;
	logic [VPN_BITS-1:0] limit_q;
	logic                wr_en;

	assign wr_en = cfg_cyc_i & cfg_stb_i & cfg_we_i & ~cfg_ack_o;

	always_ff @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni) begin
			base_q    <= '0;
			limit_q   <= '0; // every page faults until the limit is set.
			cfg_ack_o <= 1'b0;
		end else begin
			cfg_ack_o <= cfg_cyc_i & cfg_stb_i & ~cfg_ack_o;
			if (wr_en && !cfg_adr_i)
				base_q <= cfg_dat_i[PPN_BITS-1:0];
			if (wr_en && cfg_adr_i)
				limit_q <= cfg_dat_i[VPN_BITS-1:0];
		end
	end

	assign cfg_dat_o = cfg_adr_i ? {{(store_pkg::XLEN-VPN_BITS){1'b0}}, limit_q}
		: {{(store_pkg::XLEN-PPN_BITS){1'b0}}, base_q};

	// flat single-page translation.
	assign paddr_o = {base_q, vaddr_i[store_pkg::PAGE_BITS-1:0]};
	assign fault_o = vaddr_i[store_pkg::VLEN-1:store_pkg::PAGE_BITS] >= limit_q;

	ack_only_with_stb: assert property (@(posedge clk_i) disable iff (!rst_ni)
		cfg_ack_o |-> cfg_stb_i);

endmodule

`default_nettype wire

//--- verilog/store_issue.sv
`timescale 1ns/1ps
`default_nettype none

module store_issue (
	input  wire                                   clk_i,
	input  wire                                   rst_ni,
	input  wire                                   flush_i,
	input  wire                                   valid_i,
	output logic                                  ready_o,
	input  wire store_pkg::op_t                   op_i,
	input  wire [store_pkg::VLEN-1:0]             vaddr_i,
	input  wire [store_pkg::XLEN-1:0]             data_i,
	input  wire [3:0]                             be_i,
	input  wire [store_pkg::TRANS_ID_BITS-1:0]    trans_id_i,
	output logic                                  valid_o,
	output logic [store_pkg::TRANS_ID_BITS-1:0]   trans_id_o,
	output logic                                  fault_o,
	output logic [store_pkg::VLEN-1:0]            vaddr_o,
	input  wire [store_pkg::PLEN-1:0]             paddr_i,
	input  wire                                   xlate_fault_i,
	output logic                                  sq_valid_o,
	input  wire                                   sq_ready_i,
	output logic [store_pkg::PLEN-1:0]            sq_paddr_o,
	output logic [store_pkg::XLEN-1:0]            sq_data_o,
	output logic [3:0]                            sq_be_o,
	output logic                                  amo_valid_o,
	input  wire                                   amo_ready_i,
	output store_pkg::op_t                        amo_op_o
);

	typedef enum logic {S_IDLE, S_WB} state_e;

	state_e                              state_q;
	logic                                init_q;
	logic                                accept;
	logic                                in_amo;
	logic                                held_amo;
	logic                                tgt_ready;
	logic [5:0]                          shamt;
	logic [store_pkg::XLEN-1:0]          data_rot;
	store_pkg::op_t                      op_q;
	logic [store_pkg::PLEN-1:0]          paddr_q;
	logic [store_pkg::XLEN-1:0]          data_q;
	logic [3:0]                          be_q;
	logic [store_pkg::TRANS_ID_BITS-1:0] trans_id_q;
	logic                                fault_q;

	assign vaddr_o  = vaddr_i; // translated in the same cycle.
	assign in_amo   = store_pkg::is_amo(op_i);
	assign held_amo = store_pkg::is_amo(op_q);

	assign tgt_ready = in_amo ? amo_ready_i : sq_ready_i;
	// only idle accepts, so the write-back hand-over never has to stall.
	assign ready_o = init_q & tgt_ready & ~flush_i & (state_q == S_IDLE);
	assign accept  = valid_i & ready_o;

	// move the store data to the byte lane of its address.
	assign shamt    = {vaddr_i[1:0], 3'b000};
	assign data_rot = (data_i << shamt) | (data_i >> (6'd32 - shamt));

	always_ff @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni) begin
			state_q <= S_IDLE;
			init_q  <= 1'b0;
		end else begin
			init_q  <= 1'b1;
			state_q <= accept ? S_WB : S_IDLE;
		end
	end

	always_ff @(posedge clk_i) begin
		if (accept) begin
			op_q       <= op_i;
			paddr_q    <= paddr_i;
			data_q     <= in_amo ? data_i : data_rot; // amo operand stays a word.
			be_q       <= in_amo ? 4'hf : be_i;
			trans_id_q <= trans_id_i;
			fault_q    <= xlate_fault_i;
		end
	end

	assign valid_o    = state_q == S_WB;
	assign trans_id_o = trans_id_q;
	assign fault_o    = valid_o & fault_q;

	// faulted or flushed operations go nowhere.
	assign sq_valid_o  = valid_o & ~fault_q & ~held_amo & ~flush_i;
	assign amo_valid_o = valid_o & ~fault_q & held_amo & ~flush_i;
	assign sq_paddr_o  = paddr_q;
	assign sq_data_o   = data_q;
	assign sq_be_o     = be_q;
	assign amo_op_o    = op_q;

	sq_handover_ready: assert property (@(posedge clk_i) disable iff (!rst_ni)
		sq_valid_o |-> sq_ready_i);

	amo_handover_ready: assert property (@(posedge clk_i) disable iff (!rst_ni)
		amo_valid_o |-> amo_ready_i);

endmodule

`default_nettype wire

//--- verilog/store_queue.sv
`timescale 1ns/1ps
`default_nettype none

module store_queue #(
	parameter int QUEUE_DEPTH = 4
) (
	input  wire                           clk_i,
	input  wire                           rst_ni,
	input  wire                           flush_i,
	input  wire                           valid_i,
	output logic                          ready_o,
	input  wire [store_pkg::PLEN-1:0]     paddr_i,
	input  wire [store_pkg::XLEN-1:0]     data_i,
	input  wire [3:0]                     be_i,
	input  wire                           commit_i,
	output logic                          commit_ready_o,
	output logic                          no_st_pending_o,
	output logic                          req_o,
	input  wire                           gnt_i,
	output logic [store_pkg::PLEN-3:0]    adr_o,
	output logic [3:0]                    sel_o,
	output logic [store_pkg::XLEN-1:0]    dat_o,
	input  wire                           done_i
);

	localparam int PTR_W = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
	localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);

	logic [store_pkg::PLEN-3:0] adr_mem [QUEUE_DEPTH];
	logic [store_pkg::XLEN-1:0] dat_mem [QUEUE_DEPTH];
	logic [3:0]                 sel_mem [QUEUE_DEPTH];

	logic [PTR_W-1:0] issue_ptr_q;  // oldest committed entry.
	logic [PTR_W-1:0] commit_ptr_q; // oldest speculative entry.
	logic [PTR_W-1:0] spec_ptr_q;   // next free slot.
	logic [CNT_W-1:0] com_cnt_q;    // committed, in-flight included.
	logic [CNT_W-1:0] spec_cnt_q;
	logic             inflight_q;
	logic             push;
	logic             commit;

	function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
		return (ptr == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : ptr + 1'b1;
	endfunction

	assign ready_o        = (com_cnt_q + spec_cnt_q) < QUEUE_DEPTH;
	assign commit_ready_o = spec_cnt_q != '0;
	assign push           = valid_i & ready_o & ~flush_i;
	assign commit         = commit_i & commit_ready_o;

	always_ff @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni) begin
			issue_ptr_q  <= '0;
			commit_ptr_q <= '0;
			spec_ptr_q   <= '0;
			com_cnt_q    <= '0;
			spec_cnt_q   <= '0;
			inflight_q   <= 1'b0;
		end else begin
			if (push)
				spec_ptr_q <= ptr_inc(spec_ptr_q);
			if (commit)
				commit_ptr_q <= ptr_inc(commit_ptr_q);
			if (done_i)
				issue_ptr_q <= ptr_inc(issue_ptr_q);
			com_cnt_q  <= com_cnt_q + CNT_W'(commit) - CNT_W'(done_i);
			spec_cnt_q <= spec_cnt_q + CNT_W'(push) - CNT_W'(commit);
			if (gnt_i)
				inflight_q <= 1'b1;
			else if (done_i)
				inflight_q <= 1'b0;
			// a commit in the flush cycle still survives.
			if (flush_i) begin
				spec_ptr_q <= commit ? ptr_inc(commit_ptr_q) : commit_ptr_q;
				spec_cnt_q <= '0;
			end
		end
	end

	always_ff @(posedge clk_i) begin
		if (push) begin
			adr_mem[spec_ptr_q] <= paddr_i[store_pkg::PLEN-1:2];
			dat_mem[spec_ptr_q] <= data_i;
			sel_mem[spec_ptr_q] <= be_i;
		end
	end

	assign req_o = (com_cnt_q != '0) & ~inflight_q;
	assign adr_o = adr_mem[issue_ptr_q];
	assign sel_o = sel_mem[issue_ptr_q];
	assign dat_o = dat_mem[issue_ptr_q];

	assign no_st_pending_o = (com_cnt_q == '0) & ~inflight_q;

	occupancy_within_depth: assert property (@(posedge clk_i) disable iff (!rst_ni)
		com_cnt_q + spec_cnt_q <= QUEUE_DEPTH);

endmodule

`default_nettype wire

//--- verilog/amo_unit.sv
`timescale 1ns/1ps
`default_nettype none

module amo_unit (
	input  wire                           clk_i,
	input  wire                           rst_ni,
	input  wire                           flush_i,
	input  wire                           valid_i,
	output logic                          ready_o,
	input  wire [store_pkg::PLEN-1:0]     paddr_i,
	input  wire store_pkg::op_t           op_i,
	input  wire [store_pkg::XLEN-1:0]     data_i,
	input  wire                           amo_commit_i,
	input  wire                           no_st_pending_i,
	output logic                          req_o,
	output logic [store_pkg::PLEN-3:0]    adr_o,
	output logic [store_pkg::XLEN-1:0]    wdat_o,
	input  wire [store_pkg::XLEN-1:0]     rdat_i,
	input  wire                           rd_done_i,
	input  wire                           wr_done_i,
	output logic                          amo_done_o,
	output logic [store_pkg::XLEN-1:0]    amo_result_o
);

	typedef enum logic [1:0] {A_IDLE, A_WAIT, A_READ, A_WRITE} state_e;

	state_e                     state_q;
	logic                       committed_q;
	store_pkg::op_t             op_q;
	logic [store_pkg::PLEN-3:0] adr_q;
	logic [store_pkg::XLEN-1:0] opnd_q;
	logic [store_pkg::XLEN-1:0] old_q;

	assign ready_o = state_q == A_IDLE;
	assign req_o   = (state_q == A_READ) || (state_q == A_WRITE);
	assign adr_o   = adr_q;
	assign wdat_o  = store_pkg::amo_result(op_q, old_q, opnd_q);
	assign amo_result_o = old_q;

	always_ff @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni) begin
			state_q     <= A_IDLE;
			committed_q <= 1'b0;
			amo_done_o  <= 1'b0;
		end else begin
			amo_done_o <= 1'b0;
			case (state_q)
				A_IDLE: if (valid_i) begin
					state_q     <= A_WAIT;
					committed_q <= 1'b0;
				end
				A_WAIT: begin
					if (amo_commit_i)
						committed_q <= 1'b1;
					if (flush_i && !committed_q && !amo_commit_i)
						state_q <= A_IDLE;
					else if (committed_q && no_st_pending_i)
						state_q <= A_READ; // older stores have all drained.
				end
				A_READ: if (rd_done_i)
					state_q <= A_WRITE;
				default: if (wr_done_i) begin
					state_q    <= A_IDLE;
					amo_done_o <= 1'b1;
				end
			endcase
		end
	end

	always_ff @(posedge clk_i) begin
		if (valid_i && ready_o) begin
			op_q   <= op_i;
			adr_q  <= paddr_i[store_pkg::PLEN-1:2];
			opnd_q <= data_i;
		end
		if (rd_done_i)
			old_q <= rdat_i;
	end

endmodule

`default_nettype wire

//--- verilog/wb_store_master.sv
`timescale 1ns/1ps
`default_nettype none

module wb_store_master (
	input  wire                           clk_i,
	input  wire                           rst_ni,
	input  wire                           q_req_i,
	output logic                          q_gnt_o,
	input  wire [store_pkg::PLEN-3:0]     q_adr_i,
	input  wire [3:0]                     q_sel_i,
	input  wire [store_pkg::XLEN-1:0]     q_dat_i,
	output logic                          q_done_o,
	input  wire                           amo_req_i,
	input  wire [store_pkg::PLEN-3:0]     amo_adr_i,
	input  wire [store_pkg::XLEN-1:0]     amo_wdat_i,
	output logic [store_pkg::XLEN-1:0]    amo_rdat_o,
	output logic                          amo_rd_done_o,
	output logic                          amo_wr_done_o,
	output logic                          wb_cyc_o,
	output logic                          wb_stb_o,
	output logic                          wb_we_o,
	output logic [store_pkg::PLEN-3:0]    wb_adr_o,
	output logic [3:0]                    wb_sel_o,
	output logic [store_pkg::XLEN-1:0]    wb_dat_o,
	input  wire [store_pkg::XLEN-1:0]     wb_dat_i,
	input  wire                           wb_ack_i
);

	logic own_amo_q; // the current cycle belongs to the amo unit.
	logic amo_wr_q;  // next amo cycle is the write half.
	logic ack;

	assign ack           = wb_cyc_o & wb_ack_i;
	assign q_gnt_o       = ~wb_cyc_o & q_req_i & ~amo_req_i;
	assign q_done_o      = ack & ~own_amo_q;
	assign amo_rd_done_o = ack & own_amo_q & ~amo_wr_q;
	assign amo_wr_done_o = ack & own_amo_q & amo_wr_q;
	assign amo_rdat_o    = wb_dat_i;

	always_ff @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni) begin
			wb_cyc_o  <= 1'b0;
			wb_stb_o  <= 1'b0;
			own_amo_q <= 1'b0;
			amo_wr_q  <= 1'b0;
		end else if (ack) begin
			wb_cyc_o <= 1'b0;
			wb_stb_o <= 1'b0;
			if (own_amo_q)
				amo_wr_q <= ~amo_wr_q;
		end else if (!wb_cyc_o && (amo_req_i || q_req_i)) begin
			wb_cyc_o  <= 1'b1;
			wb_stb_o  <= 1'b1;
			own_amo_q <= amo_req_i;
		end
	end

	// loaded while idle, held for the whole cycle.
	always_ff @(posedge clk_i) begin
		if (!wb_cyc_o) begin
			wb_we_o  <= ~amo_req_i | amo_wr_q;
			wb_adr_o <= amo_req_i ? amo_adr_i : q_adr_i;
			wb_sel_o <= amo_req_i ? 4'hf : q_sel_i;
			wb_dat_o <= amo_req_i ? amo_wdat_i : q_dat_i;
		end
	end

	// the slave acks only inside a cycle.
	ack_inside_cyc: assert property (@(posedge clk_i) disable iff (!rst_ni)
		wb_ack_i |-> wb_cyc_o);

endmodule

`default_nettype wire

//--- verilog/store_top.sv
`timescale 1ns/1ps
`default_nettype none

module store_top #(
	parameter int QUEUE_DEPTH = 4
) (
	input  wire                                   clk_i,
	input  wire                                   rst_ni,
	input  wire                                   flush_i,
	input  wire                                   valid_i,
	output logic                                  ready_o,
	input  wire store_pkg::op_t                   op_i,
	input  wire [store_pkg::VLEN-1:0]             vaddr_i,
	input  wire [store_pkg::XLEN-1:0]             data_i,
	input  wire [3:0]                             be_i,
	input  wire [store_pkg::TRANS_ID_BITS-1:0]    trans_id_i,
	output logic                                  valid_o,
	output logic [store_pkg::TRANS_ID_BITS-1:0]   trans_id_o,
	output logic                                  fault_o,
	input  wire                                   commit_i,
	output logic                                  commit_ready_o,
	input  wire                                   amo_commit_i,
	output logic                                  amo_done_o,
	output logic [store_pkg::XLEN-1:0]            amo_result_o,
	output logic                                  no_st_pending_o,
	input  wire                                   cfg_cyc_i,
	input  wire                                   cfg_stb_i,
	input  wire                                   cfg_we_i,
	input  wire                                   cfg_adr_i,
	input  wire [store_pkg::XLEN-1:0]             cfg_dat_i,
	output logic [store_pkg::XLEN-1:0]            cfg_dat_o,
	output logic                                  cfg_ack_o,
	output logic                                  wb_cyc_o,
	output logic                                  wb_stb_o,
	output logic                                  wb_we_o,
	output logic [store_pkg::PLEN-3:0]            wb_adr_o,
	output logic [3:0]                            wb_sel_o,
	output logic [store_pkg::XLEN-1:0]            wb_dat_o,
	input  wire [store_pkg::XLEN-1:0]             wb_dat_i,
	input  wire                                   wb_ack_i
);

	logic [store_pkg::VLEN-1:0] vaddr;
	logic [store_pkg::PLEN-1:0] paddr;
	logic                       xlate_fault;
	logic                       sq_valid;
	logic                       sq_ready;
	logic [store_pkg::PLEN-1:0] st_paddr;
	logic [store_pkg::XLEN-1:0] st_data;
	logic [3:0]                 st_be;
	logic                       amo_valid;
	logic                       amo_ready;
	store_pkg::op_t             amo_op;
	logic                       q_req;
	logic                       q_gnt;
	logic [store_pkg::PLEN-3:0] q_adr;
	logic [3:0]                 q_sel;
	logic [store_pkg::XLEN-1:0] q_dat;
	logic                       q_done;
	logic                       amo_req;
	logic [store_pkg::PLEN-3:0] amo_adr;
	logic [store_pkg::XLEN-1:0] amo_wdat;
	logic [store_pkg::XLEN-1:0] amo_rdat;
	logic                       amo_rd_done;
	logic                       amo_wr_done;

	store_xlate_regs i_xlate (
		.clk_i, .rst_ni,
		.cfg_cyc_i, .cfg_stb_i, .cfg_we_i, .cfg_adr_i, .cfg_dat_i, .cfg_dat_o, .cfg_ack_o,
		.vaddr_i (vaddr),
		.paddr_o (paddr),
		.fault_o (xlate_fault)
	);

	store_issue i_issue (
		.clk_i, .rst_ni, .flush_i,
		.valid_i, .ready_o, .op_i, .vaddr_i, .data_i, .be_i, .trans_id_i,
		.valid_o, .trans_id_o, .fault_o,
		.vaddr_o       (vaddr),
		.paddr_i       (paddr),
		.xlate_fault_i (xlate_fault),
		.sq_valid_o    (sq_valid),
		.sq_ready_i    (sq_ready),
		.sq_paddr_o    (st_paddr),
		.sq_data_o     (st_data),
		.sq_be_o       (st_be),
		.amo_valid_o   (amo_valid),
		.amo_ready_i   (amo_ready),
		.amo_op_o      (amo_op)
	);

	store_queue #(.QUEUE_DEPTH(QUEUE_DEPTH)) i_queue (
		.clk_i, .rst_ni, .flush_i,
		.valid_i  (sq_valid),
		.ready_o  (sq_ready),
		.paddr_i  (st_paddr),
		.data_i   (st_data),
		.be_i     (st_be),
		.commit_i, .commit_ready_o, .no_st_pending_o,
		.req_o    (q_req),
		.gnt_i    (q_gnt),
		.adr_o    (q_adr),
		.sel_o    (q_sel),
		.dat_o    (q_dat),
		.done_i   (q_done)
	);

	amo_unit i_amo (
		.clk_i, .rst_ni, .flush_i,
		.valid_i         (amo_valid),
		.ready_o         (amo_ready),
		.paddr_i         (st_paddr),
		.op_i            (amo_op),
		.data_i          (st_data),
		.amo_commit_i,
		.no_st_pending_i (no_st_pending_o),
		.req_o           (amo_req),
		.adr_o           (amo_adr),
		.wdat_o          (amo_wdat),
		.rdat_i          (amo_rdat),
		.rd_done_i       (amo_rd_done),
		.wr_done_i       (amo_wr_done),
		.amo_done_o, .amo_result_o
	);

	wb_store_master i_master (
		.clk_i, .rst_ni,
		.q_req_i       (q_req),
		.q_gnt_o       (q_gnt),
		.q_adr_i       (q_adr),
		.q_sel_i       (q_sel),
		.q_dat_i       (q_dat),
		.q_done_o      (q_done),
		.amo_req_i     (amo_req),
		.amo_adr_i     (amo_adr),
		.amo_wdat_i    (amo_wdat),
		.amo_rdat_o    (amo_rdat),
		.amo_rd_done_o (amo_rd_done),
		.amo_wr_done_o (amo_wr_done),
		.wb_cyc_o, .wb_stb_o, .wb_we_o, .wb_adr_o, .wb_sel_o, .wb_dat_o,
		.wb_dat_i, .wb_ack_i
	);

endmodule

`default_nettype wire

//--- bench/tb_store_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_store_top;

	localparam logic [21:0] BASE  = 22'h2a5c3;
	localparam logic [19:0] LIMIT = 20'h00010;
	localparam int          TMO   = 400;

	logic           clk_i = 1'b0;
	logic           rst_ni = 1'b0;
	logic           flush_i, valid_i, commit_i, amo_commit_i;
	store_pkg::op_t op_i;
	logic [31:0]    vaddr_i, data_i, cfg_dat_i, wb_dat_i;
	logic [3:0]     be_i;
	logic [2:0]     trans_id_i;
	logic           cfg_cyc_i, cfg_stb_i, cfg_we_i, cfg_adr_i, wb_ack_i;
	logic           ready_o, valid_o, fault_o, commit_ready_o, amo_done_o, no_st_pending_o;
	logic [2:0]     trans_id_o;
	logic [31:0]    amo_result_o, cfg_dat_o, wb_adr_o, wb_dat_o;
	logic           cfg_ack_o, wb_cyc_o, wb_stb_o, wb_we_o;
	logic [3:0]     wb_sel_o;

	logic [31:0] model_mem [logic [31:0]];
	logic [31:0] shadow [logic [31:0]];
	logic [31:0] wr_log[$];
	logic [31:0] exp_log[$];
	logic [3:0]  exp_wb[$];  // {fault, id}.
	logic [31:0] exp_old[$];
	logic [31:0] spec_adr[$];
	logic [31:0] spec_dat[$];
	logic [3:0]  spec_be[$];
	logic [1:0]  spec_off[$];
	store_pkg::op_t amo_op_p;
	logic [31:0] amo_adr_p, amo_dat_p;
	int          errors = 0;
	int          tests = 0;
	int          err_base = 0;
	int          amo_done_cnt = 0;
	int          ack_wait = 0;
	logic [2:0]  next_id = '0;

	store_top #(.QUEUE_DEPTH(4)) dut (.*);

	always #10 clk_i = ~clk_i;

	// fill pattern for untouched words.
	function automatic logic [31:0] init_word(input logic [31:0] a);
		return a ^ {a[15:0], a[31:16]} ^ 32'h5a5a_c3c3;
	endfunction

	function automatic logic [31:0] word_addr(input logic [31:0] va);
		return {BASE, va[11:2]};
	endfunction

	// expected memory word after a store or an amo.
	function automatic logic [31:0] ref_update(input store_pkg::op_t op, input logic [31:0] old,
			input logic [31:0] d, input logic [3:0] be, input logic [1:0] off);
		logic [31:0] res;
		res = old;
		case (op)
			store_pkg::OP_AMO_SWAP: res = d;
			store_pkg::OP_AMO_ADD:  res = old + d;
			store_pkg::OP_AMO_AND:  res = old & d;
			store_pkg::OP_AMO_OR:   res = old | d;
			store_pkg::OP_AMO_XOR:  res = old ^ d;
			store_pkg::OP_AMO_MAX:  res = ($signed(old) > $signed(d)) ? old : d;
			store_pkg::OP_AMO_MIN:  res = ($signed(old) < $signed(d)) ? old : d;
			store_pkg::OP_AMO_MAXU: res = (old > d) ? old : d;
			store_pkg::OP_AMO_MINU: res = (old < d) ? old : d;
			default: begin
				// lane i takes data byte i minus the offset.
				for (int i = 0; i < 4; i++)
					if (be[i])
						res[i*8 +: 8] = d[((i - off) & 3) * 8 +: 8];
			end
		endcase
		return res;
	endfunction

	function automatic logic [31:0] shadow_rd(input logic [31:0] a);
		return shadow.exists(a) ? shadow[a] : init_word(a);
	endfunction

	function automatic logic [31:0] model_rd(input logic [31:0] a);
		return model_mem.exists(a) ? model_mem[a] : init_word(a);
	endfunction

	task automatic report_mismatch(input string sig, input logic [31:0] exp,
			input logic [31:0] got);
		$display("MISMATCH %s expected %h got %h", sig, exp, got);
		errors++;
	endtask

	task automatic report_error(input string what);
		$display("ERROR %s", what);
		errors++;
	endtask

	task automatic abort_on_timeout(input string what);
		$display("timeout while waiting for %s", what);
		$display("Checks failed");
		$finish;
	endtask

	// wishbone word memory with 0 to 3 wait cycles.
	always @(posedge clk_i or negedge rst_ni) begin
		logic [31:0] w;
		if (!rst_ni) begin
			wb_ack_i <= 1'b0;
		end else begin
			wb_ack_i <= 1'b0;
			if (wb_cyc_o && wb_stb_o && !wb_ack_i) begin
				if (ack_wait == 0) begin
					wb_ack_i <= 1'b1;
					ack_wait = $urandom_range(0, 3);
					w = model_rd(wb_adr_o);
					if (wb_we_o) begin
						for (int i = 0; i < 4; i++)
							if (wb_sel_o[i])
								w[i*8 +: 8] = wb_dat_o[i*8 +: 8];
						model_mem[wb_adr_o] = w;
						wr_log.push_back(wb_adr_o);
					end else begin
						wb_dat_i <= w;
						if (!no_st_pending_o)
							report_error("amo read started while stores were pending");
					end
				end else begin
					ack_wait--;
				end
			end
		end
	end

	// compares write-back and amo results as they appear.
	always @(posedge clk_i) begin
		logic [3:0] e;
		if (!rst_ni) begin
			if (wb_cyc_o || valid_o || amo_done_o)
				report_error("bus, write-back or amo activity during reset");
		end else begin
			if (valid_o) begin
				if (exp_wb.size() == 0) begin
					report_error("valid_o without an issued operation");
				end else begin
					e = exp_wb.pop_front();
					if (trans_id_o != e[2:0])
						report_mismatch("trans_id_o", e[2:0], trans_id_o);
					if (fault_o != e[3])
						report_mismatch("fault_o", e[3], fault_o);
				end
			end
			if (amo_done_o) begin
				amo_done_cnt++;
				if (exp_old.size() == 0)
					report_error("amo_done_o without a committed amo");
				else if (amo_result_o != exp_old[0])
					report_mismatch("amo_result_o", exp_old[0], amo_result_o);
				if (exp_old.size() != 0)
					void'(exp_old.pop_front());
			end
		end
	end

	task automatic cfg_write(input logic adr, input logic [31:0] d);
		int n;
		@(posedge clk_i);
		cfg_cyc_i <= 1'b1;
		cfg_stb_i <= 1'b1;
		cfg_we_i  <= 1'b1;
		cfg_adr_i <= adr;
		cfg_dat_i <= d;
		n = 0;
		do begin
			@(posedge clk_i);
			if (++n > TMO)
				abort_on_timeout("cfg_ack_o");
		end while (!cfg_ack_o);
		cfg_cyc_i <= 1'b0;
		cfg_stb_i <= 1'b0;
		cfg_we_i  <= 1'b0;
	endtask

	task automatic cfg_read(input logic adr, input logic [31:0] exp);
		int n;
		@(posedge clk_i);
		cfg_cyc_i <= 1'b1;
		cfg_stb_i <= 1'b1;
		cfg_we_i  <= 1'b0;
		cfg_adr_i <= adr;
		n = 0;
		do begin
			@(posedge clk_i);
			if (++n > TMO)
				abort_on_timeout("cfg_ack_o on a read");
		end while (!cfg_ack_o);
		if (cfg_dat_o != exp)
			report_mismatch("cfg_dat_o", exp, cfg_dat_o);
		cfg_cyc_i <= 1'b0;
		cfg_stb_i <= 1'b0;
	endtask

	task automatic issue_op(input store_pkg::op_t op, input logic [31:0] va,
			input logic [31:0] d, input logic [3:0] be, input logic fault);
		int n;
		@(posedge clk_i);
		valid_i    <= 1'b1;
		op_i       <= op;
		vaddr_i    <= va;
		data_i     <= d;
		be_i       <= be;
		trans_id_i <= next_id;
		n = 0;
		do begin
			@(posedge clk_i);
			if (++n > TMO)
				abort_on_timeout("ready_o");
		end while (!ready_o);
		valid_i <= 1'b0;
		exp_wb.push_back({fault, next_id});
		next_id++;
		if (!fault && op >= store_pkg::OP_AMO_SWAP) begin
			amo_op_p  = op;
			amo_adr_p = word_addr(va);
			amo_dat_p = d;
		end else if (!fault) begin
			spec_adr.push_back(word_addr(va));
			spec_dat.push_back(d);
			spec_be.push_back(be);
			spec_off.push_back(va[1:0]);
		end
	endtask

	task automatic commit_store();
		int n;
		logic [31:0] a;
		@(posedge clk_i);
		commit_i <= 1'b1;
		n = 0;
		do begin
			@(posedge clk_i);
			if (++n > TMO)
				abort_on_timeout("commit_ready_o");
		end while (!commit_ready_o);
		commit_i <= 1'b0;
		a = spec_adr.pop_front();
		shadow[a] = ref_update(store_pkg::OP_SW, shadow_rd(a), spec_dat.pop_front(),
			spec_be.pop_front(), spec_off.pop_front());
		exp_log.push_back(a);
	endtask

	task automatic run_amo(input store_pkg::op_t op, input logic [31:0] va,
			input logic [31:0] d);
		int n;
		int target;
		target = amo_done_cnt + 1;
		issue_op(op, va, d, 4'hf, 1'b0);
		repeat (2) @(posedge clk_i);
		amo_commit_i <= 1'b1;
		@(posedge clk_i);
		amo_commit_i <= 1'b0;
		exp_old.push_back(shadow_rd(amo_adr_p));
		shadow[amo_adr_p] = ref_update(amo_op_p, shadow_rd(amo_adr_p), amo_dat_p, 4'hf, 2'd0);
		exp_log.push_back(amo_adr_p);
		n = 0;
		while (amo_done_cnt < target) begin
			@(posedge clk_i);
			if (++n > TMO)
				abort_on_timeout("amo_done_o");
		end
	endtask

	task automatic wait_idle();
		int n;
		n = 0;
		do begin
			@(posedge clk_i);
			if (++n > TMO)
				abort_on_timeout("an idle store path");
		end while (!no_st_pending_o || wb_cyc_o);
		repeat (2) @(posedge clk_i);
	endtask

	task automatic finish_test(input string name);
		foreach (shadow[a])
			if (model_rd(a) != shadow[a])
				report_mismatch($sformatf("mem[%h]", a), shadow[a], model_rd(a));
		foreach (model_mem[a])
			if (!shadow.exists(a) && model_mem[a] != init_word(a))
				report_mismatch($sformatf("mem[%h]", a), init_word(a), model_mem[a]);
		if (wr_log.size() != exp_log.size())
			report_mismatch("bus write count", exp_log.size(), wr_log.size());
		else
			foreach (exp_log[i])
				if (wr_log[i] != exp_log[i])
					report_mismatch("wb_adr_o", exp_log[i], wr_log[i]);
		if (exp_wb.size() != 0)
			report_error("write-back missing for an issued operation");
		wr_log.delete();
		exp_log.delete();
		tests++;
		$display("test %0d %s: %0d errors", tests, name, errors - err_base);
		err_base = errors;
	endtask

	initial begin
		void'($urandom(32'h0945fbbb));
		{flush_i, valid_i, commit_i, amo_commit_i} = '0;
		op_i = store_pkg::OP_SW;
		{vaddr_i, data_i, cfg_dat_i, wb_dat_i} = '0;
		be_i = '0;
		trans_id_i = '0;
		{cfg_cyc_i, cfg_stb_i, cfg_we_i, cfg_adr_i} = '0;
		repeat (16) @(posedge clk_i);
		rst_ni <= 1'b1;

		repeat (3) @(posedge clk_i);
		if (!ready_o)
			report_error("ready_o stayed low after reset");
		if (!no_st_pending_o)
			report_error("no_st_pending_o low while idle");
		finish_test("reset and idle");

		cfg_write(1'b0, {10'd0, BASE});
		cfg_write(1'b1, {12'd0, LIMIT});
		cfg_read(1'b0, {10'd0, BASE});
		cfg_read(1'b1, {12'd0, LIMIT});
		issue_op(store_pkg::OP_SW, 32'h0000_0100, $urandom, 4'hf, 1'b0);
		commit_store();
		issue_op(store_pkg::OP_SH, 32'h0000_0202, 32'h0000_beef, 4'hc, 1'b0);
		issue_op(store_pkg::OP_SB, 32'h0000_0301, 32'h0000_005a, 4'h2, 1'b0);
		issue_op(store_pkg::OP_SB, 32'h0000_0303, 32'h0000_00c7, 4'h8, 1'b0);
		issue_op(store_pkg::OP_SH, 32'h0000_0300, 32'h0000_1234, 4'h3, 1'b0);
		repeat (4) commit_store();
		wait_idle();
		finish_test("word, half and byte stores");

		issue_op(store_pkg::OP_SW, 32'h0001_0040, $urandom, 4'hf, 1'b1);
		issue_op(store_pkg::OP_SW, 32'hfff0_0044, $urandom, 4'hf, 1'b1);
		repeat (4) @(posedge clk_i);
		if (commit_ready_o)
			report_error("faulted store entered the queue");
		wait_idle();
		finish_test("translation fault");

		issue_op(store_pkg::OP_SW, 32'h0000_0500, $urandom, 4'hf, 1'b0);
		issue_op(store_pkg::OP_SW, 32'h0000_0504, $urandom, 4'hf, 1'b0);
		commit_store();
		issue_op(store_pkg::OP_SW, 32'h0000_0508, $urandom, 4'hf, 1'b0);
		issue_op(store_pkg::OP_SB, 32'h0000_050d, $urandom, 4'h2, 1'b0);
		repeat (2) @(posedge clk_i);
		flush_i <= 1'b1;
		@(posedge clk_i);
		flush_i <= 1'b0;
		spec_adr.delete();
		spec_dat.delete();
		spec_be.delete();
		spec_off.delete();
		repeat (2) @(posedge clk_i);
		if (commit_ready_o)
			report_error("speculative stores survived the flush");
		wait_idle();
		finish_test("flush of speculative stores");

		for (int i = 0; i < 4; i++)
			issue_op(store_pkg::OP_SW, 32'h0000_0600 + 4 * i, $urandom, 4'hf, 1'b0);
		repeat (2) @(posedge clk_i);
		if (ready_o)
			report_error("ready_o high with a full queue");
		commit_store();
		wait_idle();
		issue_op(store_pkg::OP_SW, 32'h0000_0610, $urandom, 4'hf, 1'b0);
		repeat (4) commit_store();
		wait_idle();
		finish_test("full queue back-pressure");

		issue_op(store_pkg::OP_SW, 32'h0000_0700, $urandom, 4'hf, 1'b0);
		commit_store();
		run_amo(store_pkg::OP_AMO_ADD, 32'h0000_0700, $urandom);
		for (int k = 0; k < 9; k++)
			run_amo(store_pkg::op_t'(3 + k), 32'h0000_0710 + 4 * (k % 3), $urandom);
		wait_idle();
		finish_test("amo operations");

		$display("%0d tests, %0d errors", tests, errors);
		if (errors == 0) begin
			$display("All checks passed");
		end else begin
			$display("Checks failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- tb.f
verilog/store_pkg.sv
verilog/store_xlate_regs.sv
verilog/store_issue.sv
verilog/store_queue.sv
verilog/amo_unit.sv
verilog/wb_store_master.sv
verilog/store_top.sv
bench/tb_store_top.sv

//--- run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	-f tb.f --top-module tb_store_top -o tb_sim

./obj_dir/tb_sim | tee sim.log

if grep -q "Checks failed" sim.log; then
	exit 1
fi
grep -q "All checks passed" sim.log
